// ==== hw/hps_sys_cfg.svh ====
// HPS host port and audio block configuration
// Word and command widths, command codes, register reset values
// and the depth of the host port synchronizer

`ifndef HPS_SYS_CFG_SVH
`define HPS_SYS_CFG_SVH

// Host word and command byte
`define HPS_WORD_W      16
`define HPS_CMD_W       8

// Input register stages on the host port
`define HPS_SYNC_STAGES 2

// Command codes seen in the first word of a frame
`define HPS_CMD_CFG     8'h01
`define HPS_CMD_LED     8'h25
`define HPS_CMD_VOL     8'h26

// Attenuation field, top bit mutes
`define HPS_ATT_W       5

// Register values after reset
`define HPS_CFG_RST     16'h0000
`define HPS_VOL_RST     5'd0

`endif

// ==== hw/hps_sys_pkg.sv ====
// HPS system types
// Command and crossfeed enums, audio sample and host word types

`default_nettype none

`include "hps_sys_cfg.svh"

package hps_sys_pkg;

	// Decoded frame command
	typedef enum logic [`HPS_CMD_W-1:0] {
		CMD_NONE = 8'h00,
		CMD_CFG  = `HPS_CMD_CFG,
		CMD_LED  = `HPS_CMD_LED,
		CMD_VOL  = `HPS_CMD_VOL
	} hps_cmd_e;

	// Crossfeed between the stereo channels
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_LOW  = 2'd1,
		MIX_MID  = 2'd2,
		MIX_FULL = 2'd3
	} mix_mode_e;

	typedef logic signed [15:0] sample_t;
	typedef logic signed [16:0] acc_t;

	typedef logic [`HPS_WORD_W-1:0] hps_word_t;

endpackage

`default_nettype wire

// ==== hw/hps_word_if.sv ====
// Host word channel
// Received words and framing from the host link to the register file,
// one strobe per word and no back-pressure

`default_nettype none

interface hps_word_if;

	logic                   word_stb;
	hps_sys_pkg::hps_word_t word;
	logic                   in_frame;
	logic                   frame_end;

	// Link side drives everything
	modport link (
		output word_stb,
		output word,
		output in_frame,
		output frame_end
	);

	modport regs (
		input word_stb,
		input word,
		input in_frame,
		input frame_end
	);

endinterface

`default_nettype wire

// ==== hw/hps_io_link.sv ====
// Host port link
// Synchronizes the toggling host clock, frame line and data word,
// issues one strobe per rising clock line and answers with an
// acknowledge that follows the synchronized clock line

`default_nettype none

`include "hps_sys_cfg.svh"

module hps_io_link (
	input  wire                    clk_sys,
	input  wire                    resetd,
	input  wire                    i_io_clk,
	input  wire                    i_io_uio,
	input  wire hps_sys_pkg::hps_word_t i_io_din,
	output logic                   o_io_ack,
	hps_word_if.link               wd
);

	localparam int SYNC_N = `HPS_SYNC_STAGES;

	logic [SYNC_N-1:0]      clk_sync;
	logic [SYNC_N-1:0]      uio_sync;
	hps_sys_pkg::hps_word_t din_sync [SYNC_N];
	logic                   io_clk_s;
	logic                   io_uio_s;
	logic                   frame_q;

	assign io_clk_s = clk_sync[SYNC_N-1];
	assign io_uio_s = uio_sync[SYNC_N-1];

	//////////////////////
	// Input synchronizer
	//////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_sync <= '0;
			uio_sync <= '0;
		end else begin
			clk_sync <= {clk_sync[SYNC_N-2:0], i_io_clk};
			uio_sync <= {uio_sync[SYNC_N-2:0], i_io_uio};
		end
	end

	// Data word rides alongside the clock line
	always_ff @(posedge clk_sys) begin
		din_sync[0] <= i_io_din;
		for (int i = 1; i < SYNC_N; i++) begin
			din_sync[i] <= din_sync[i-1];
		end
	end

	//////////////////////
	// Strobe and acknowledge
	//////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_io_ack    <= 1'b0;
			wd.word_stb <= 1'b0;
			frame_q     <= 1'b0;
		end else begin
			// Ack is the previous clock level, so a rising edge shows as clk high, ack low
			o_io_ack    <= io_clk_s;
			wd.word_stb <= io_clk_s & ~o_io_ack;
			frame_q     <= io_uio_s;
		end
	end

	// Captured once per rising clock line
	always_ff @(posedge clk_sys) begin
		if (io_clk_s && !o_io_ack) begin
			wd.word <= din_sync[SYNC_N-1];
		end
	end

	assign wd.in_frame  = io_uio_s;
	assign wd.frame_end = frame_q & ~io_uio_s;

endmodule

`default_nettype wire

// ==== hw/hps_cmd_regs.sv ====
// Host command register file
// The first word of a frame selects a command, later words update
// the configuration, LED override or volume register

`default_nettype none

`include "hps_sys_cfg.svh"

module hps_cmd_regs (
	input  wire                    clk_sys,
	input  wire                    resetd,
	hps_word_if.regs               wd,
	output hps_sys_pkg::hps_word_t o_cfg,
	output logic [7:0]             o_led_mask,
	output logic [7:0]             o_led_state,
	output logic [`HPS_ATT_W-1:0]  o_vol_att
);

	logic                  has_cmd;
	hps_sys_pkg::hps_cmd_e cmd;

	// Unknown codes map to CMD_NONE and are then ignored
	function automatic hps_sys_pkg::hps_cmd_e cmd_decode(input logic [`HPS_CMD_W-1:0] code);
		hps_sys_pkg::hps_cmd_e res;
		case (code)
			`HPS_CMD_CFG: res = hps_sys_pkg::CMD_CFG;
			`HPS_CMD_LED: res = hps_sys_pkg::CMD_LED;
			`HPS_CMD_VOL: res = hps_sys_pkg::CMD_VOL;
			default:      res = hps_sys_pkg::CMD_NONE;
		endcase
		return res;
	endfunction

	//////////////////////
	// Frame decode
	//////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd     <= 1'b0;
			cmd         <= hps_sys_pkg::CMD_NONE;
			o_cfg       <= `HPS_CFG_RST;
			o_led_mask  <= '0;
			o_led_state <= '0;
			o_vol_att   <= `HPS_VOL_RST;
		end else if (wd.frame_end) begin
			has_cmd <= 1'b0;
			cmd     <= hps_sys_pkg::CMD_NONE;
		end else if (wd.word_stb && wd.in_frame) begin
			if (!has_cmd) begin
				// Command byte in the low half of the first word
				has_cmd <= 1'b1;
				cmd     <= cmd_decode(wd.word[`HPS_CMD_W-1:0]);
			end else begin
				case (cmd)
					hps_sys_pkg::CMD_CFG: begin
						o_cfg <= wd.word;
					end
					hps_sys_pkg::CMD_LED: begin
						o_led_mask  <= wd.word[15:8];
						o_led_state <= wd.word[7:0];
					end
					hps_sys_pkg::CMD_VOL: begin
						o_vol_att <= wd.word[`HPS_ATT_W-1:0];
					end
					default: begin
						// Data of an ignored command
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/status_leds.sv ====
// Status LED merge
// Front-panel power, disk and user levels from the core requests,
// and the board LED bank with the host override applied per bit

`default_nettype none

module status_leds (
	input  wire        i_led_user,
	input  wire  [1:0] i_led_power,
	input  wire  [1:0] i_led_disk,
	input  wire        i_hdd_act,
	input  wire        i_pll_locked,
	input  wire  [7:0] i_led_mask,
	input  wire  [7:0] i_led_state,
	output logic       o_led_power,
	output logic       o_led_hdd,
	output logic       o_led_user,
	output logic [7:0] o_led
);

	logic [7:0] led_dflt;

	// Power needs both request bits
	assign o_led_power = i_led_power[1] & i_led_power[0];

	// Forced mode on bit 1, otherwise request or drive activity
	assign o_led_hdd = i_led_disk[1] ? i_led_disk[0] : (i_led_disk[0] | i_hdd_act);

	assign o_led_user = i_led_user;

	// Default board pattern on the even bits plus PLL lock
	assign led_dflt = {1'b0, i_pll_locked, 1'b0, o_led_power,
		1'b0, o_led_hdd, 1'b0, o_led_user};

	assign o_led = (i_led_mask & i_led_state) | (~i_led_mask & led_dflt);

endmodule

`default_nettype wire

// ==== hw/audio_mix_chan.sv ====
// Audio mixer channel
// Settles the core sample, converts it to signed, adds the Linux sample,
// applies crossfeed from the other channel, attenuates and clamps

`default_nettype none

`include "hps_sys_cfg.svh"

module audio_mix_chan (
	input  wire                          clk_sys,
	input  wire                          resetd,
	input  wire [$bits(hps_sys_pkg::sample_t)-1:0] i_core,
	input  wire hps_sys_pkg::sample_t    i_linux,
	input  wire                          i_is_signed,
	input  wire hps_sys_pkg::mix_mode_e  i_mix,
	input  wire [`HPS_ATT_W-1:0]         i_att,
	input  wire hps_sys_pkg::sample_t    i_pre_in,
	output hps_sys_pkg::sample_t         o_pre,
	output hps_sys_pkg::sample_t         o_sample
);

	localparam int SMP_W = $bits(hps_sys_pkg::sample_t);

	logic [SMP_W-1:0]  core_d1;
	logic [SMP_W-1:0]  core_d2;
	logic [SMP_W-1:0]  core_d3;
	logic [SMP_W-1:0]  core_held;
	hps_sys_pkg::acc_t conv;
	hps_sys_pkg::acc_t sum;
	hps_sys_pkg::acc_t xfeed;
	hps_sys_pkg::acc_t atten;

	// Half-sum goes to the other channel without a register
	assign o_pre = sum[SMP_W:1];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			core_d1   <= '0;
			core_d2   <= '0;
			core_d3   <= '0;
			core_held <= '0;
			conv      <= '0;
			sum       <= '0;
			xfeed     <= '0;
			atten     <= '0;
			o_sample  <= '0;
		end else begin
			////////////////////
			// Settle
			////////////////////
			core_d1 <= i_core;
			core_d2 <= core_d1;
			core_d3 <= core_d2;
			if (core_d1 == core_d2 && core_d2 == core_d3) begin
				core_held <= core_d3;
			end

			// Unsigned samples lose one bit to fit the signed range
			if (i_is_signed) begin
				conv <= {core_held[SMP_W-1], core_held};
			end else begin
				conv <= {2'b00, core_held[SMP_W-1:1]};
			end

			sum <= conv + hps_sys_pkg::acc_t'(i_linux);

			////////////////////
			// Crossfeed
			////////////////////
			case (i_mix)
				hps_sys_pkg::MIX_NONE: xfeed <= sum;
				hps_sys_pkg::MIX_LOW:
					xfeed <= sum - (sum >>> 3) + hps_sys_pkg::acc_t'(i_pre_in >>> 2);
				hps_sys_pkg::MIX_MID:
					xfeed <= sum - (sum >>> 2) + hps_sys_pkg::acc_t'(i_pre_in >>> 1);
				hps_sys_pkg::MIX_FULL:
					xfeed <= (sum >>> 1) + hps_sys_pkg::acc_t'(i_pre_in);
				default: xfeed <= sum;
			endcase

			// Top bit mutes, the rest is a shift count
			if (i_att[`HPS_ATT_W-1]) begin
				atten <= '0;
			end else begin
				atten <= xfeed >>> i_att[`HPS_ATT_W-2:0];
			end

			// Saturate when the two top bits disagree
			if (atten[SMP_W] ^ atten[SMP_W-1]) begin
				o_sample <= {atten[SMP_W], {(SMP_W-1){~atten[SMP_W]}}};
			end else begin
				o_sample <= atten[SMP_W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/hps_sys_top.sv ====
// HPS host port and audio top level
// Host link feeding the command registers, which set the LED
// override and the attenuation of the two stereo mixer channels

`default_nettype none

`include "hps_sys_cfg.svh"

module hps_sys_top (
	input  wire                    clk_sys,
	input  wire                    resetd,

	// Host port
	input  wire                    i_io_clk,
	input  wire                    i_io_uio,
	input  wire [`HPS_WORD_W-1:0]  i_io_din,
	output logic                   o_io_ack,
	output hps_sys_pkg::hps_word_t o_cfg,

	// LED requests and outputs
	input  wire                    i_led_user,
	input  wire  [1:0]             i_led_power,
	input  wire  [1:0]             i_led_disk,
	input  wire                    i_hdd_act,
	input  wire                    i_pll_locked,
	output logic                   o_led_power,
	output logic                   o_led_hdd,
	output logic                   o_led_user,
	output logic [7:0]             o_led,

	// Audio
	input  wire  [15:0]            i_core_l,
	input  wire  [15:0]            i_core_r,
	input  wire  [15:0]            i_linux_l,
	input  wire  [15:0]            i_linux_r,
	input  wire                    i_audio_signed,
	input  wire  [1:0]             i_audio_mix,
	output hps_sys_pkg::sample_t   o_audio_l,
	output hps_sys_pkg::sample_t   o_audio_r
);

	hps_word_if u_wd_if ();

	logic [7:0]             led_mask;
	logic [7:0]             led_state;
	logic [`HPS_ATT_W-1:0]  vol_att;
	hps_sys_pkg::sample_t   pre_l;
	hps_sys_pkg::sample_t   pre_r;
	hps_sys_pkg::mix_mode_e mix_mode;

	assign mix_mode = hps_sys_pkg::mix_mode_e'(i_audio_mix);

	////////////////////
	// Host side
	////////////////////
	hps_io_link u_link (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_clk (i_io_clk),
		.i_io_uio (i_io_uio),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.wd       (u_wd_if)
	);

	hps_cmd_regs u_regs (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.wd          (u_wd_if),
		.o_cfg       (o_cfg),
		.o_led_mask  (led_mask),
		.o_led_state (led_state),
		.o_vol_att   (vol_att)
	);

	status_leds u_leds (
		.i_led_user   (i_led_user),
		.i_led_power  (i_led_power),
		.i_led_disk   (i_led_disk),
		.i_hdd_act    (i_hdd_act),
		.i_pll_locked (i_pll_locked),
		.i_led_mask   (led_mask),
		.i_led_state  (led_state),
		.o_led_power  (o_led_power),
		.o_led_hdd    (o_led_hdd),
		.o_led_user   (o_led_user),
		.o_led        (o_led)
	);

	////////////////////
	// Stereo mixer
	////////////////////
	// Each channel takes the other's half-sum for crossfeed
	audio_mix_chan u_mix_l (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_core      (i_core_l),
		.i_linux     (i_linux_l),
		.i_is_signed (i_audio_signed),
		.i_mix       (mix_mode),
		.i_att       (vol_att),
		.i_pre_in    (pre_r),
		.o_pre       (pre_l),
		.o_sample    (o_audio_l)
	);

	audio_mix_chan u_mix_r (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_core      (i_core_r),
		.i_linux     (i_linux_r),
		.i_is_signed (i_audio_signed),
		.i_mix       (mix_mode),
		.i_att       (vol_att),
		.i_pre_in    (pre_l),
		.o_pre       (pre_r),
		.o_sample    (o_audio_r)
	);

endmodule

`default_nettype wire

// ==== bench/hps_sys_asserts.sv ====
// HPS system bound checks
// Acknowledge tracking and strobe width on the host link,
// mute timing on each mixer channel

`default_nettype none

`include "hps_sys_cfg.svh"

module hps_sys_asserts (
	input wire                  clk_sys,
	input wire                  resetd,
	input wire                  io_ack,
	input wire                  io_clk,
	input wire                  word_stb,
	input wire [`HPS_ATT_W-1:0] att,
	input wire [15:0]           sample
);

	// Ack only ever moves to the host clock level three cycles back
	ack_follows_clk: assert property (@(posedge clk_sys) disable iff (resetd)
		(io_ack != $past(io_ack)) |-> (io_ack == $past(io_clk, 3)))
		else $error("acknowledge moved away from the delayed host clock level");

	stb_one_cycle: assert property (@(posedge clk_sys) disable iff (resetd)
		word_stb |=> !word_stb)
		else $error("word strobe lasted more than one cycle");

	// Attenuate then clamp, two register steps
	mute_gives_zero: assert property (@(posedge clk_sys) disable iff (resetd)
		att[`HPS_ATT_W-1] |-> ##2 (sample == 16'd0))
		else $error("muted channel did not output zero");

endmodule

bind hps_io_link hps_sys_asserts u_link_asserts (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.io_ack   (o_io_ack),
	.io_clk   (i_io_clk),
	.word_stb (wd.word_stb),
	.att      ({`HPS_ATT_W{1'b0}}),
	.sample   (16'd0)
);

bind audio_mix_chan hps_sys_asserts u_mix_asserts (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.io_ack   (1'b0),
	.io_clk   (1'b0),
	.word_stb (1'b0),
	.att      (i_att),
	.sample   (o_sample)
);

`default_nettype wire

// ==== bench/tb_hps_sys.sv ====
// HPS host port and audio testbench
// Random host frames over the toggle/acknowledge port, random LED
// requests and audio samples, checked against a reference model

`default_nettype none

`include "hps_sys_cfg.svh"

module tb_hps_sys;

	localparam int N_CFG = 6;
	localparam int N_BAD = 4;
	localparam int N_OUT = 4;
	localparam int N_LED = 6;
	localparam int N_LEDIN = 4;
	localparam int N_SUM = 16;
	localparam int N_MIX = 24;
	localparam int HOLD = 16;
	localparam int WORD_CYC = 8;
	localparam int FRAME_CYC = 4 * WORD_CYC + 4;
	localparam int PLAN_CYC = 5 + (N_CFG + N_BAD + N_LED + N_MIX) * FRAME_CYC
		+ N_OUT * WORD_CYC + N_LED * N_LEDIN + (N_SUM + N_MIX) * HOLD + 8;
	localparam int CYC_LIMIT = 2 * PLAN_CYC;

	logic clk_sys = 1'b0;
	logic resetd;
	logic i_io_clk;
	logic i_io_uio;
	logic [15:0] i_io_din;
	logic i_led_user;
	logic [1:0] i_led_power;
	logic [1:0] i_led_disk;
	logic i_hdd_act;
	logic i_pll_locked;
	logic [15:0] i_core_l;
	logic [15:0] i_core_r;
	logic [15:0] i_linux_l;
	logic [15:0] i_linux_r;
	logic i_audio_signed;
	logic [1:0] i_audio_mix;
	logic o_io_ack;
	logic [15:0] o_cfg;
	logic o_led_power;
	logic o_led_hdd;
	logic o_led_user;
	logic [7:0] o_led;
	logic signed [15:0] o_audio_l;
	logic signed [15:0] o_audio_r;

	// Model copies of the host registers
	logic [15:0] m_cfg = '0;
	logic [7:0] m_mask = '0;
	logic [7:0] m_state = '0;
	logic [4:0] m_att = '0;
	logic [15:0] fr_q[$];
	int chk_cnt = 0;
	int err_cnt = 0;
	int cyc_cnt = 0;
	int seed_ret;

	hps_sys_top u_hps_sys_top (
		.clk_sys (clk_sys), .resetd (resetd),
		.i_io_clk (i_io_clk), .i_io_uio (i_io_uio), .i_io_din (i_io_din),
		.o_io_ack (o_io_ack), .o_cfg (o_cfg),
		.i_led_user (i_led_user), .i_led_power (i_led_power), .i_led_disk (i_led_disk),
		.i_hdd_act (i_hdd_act), .i_pll_locked (i_pll_locked),
		.o_led_power (o_led_power), .o_led_hdd (o_led_hdd), .o_led_user (o_led_user),
		.o_led (o_led),
		.i_core_l (i_core_l), .i_core_r (i_core_r),
		.i_linux_l (i_linux_l), .i_linux_r (i_linux_r),
		.i_audio_signed (i_audio_signed), .i_audio_mix (i_audio_mix),
		.o_audio_l (o_audio_l), .o_audio_r (o_audio_r)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cyc_cnt = cyc_cnt + 1;
		if (cyc_cnt >= CYC_LIMIT) begin
			$display("timeout: run still busy after %0d cycles", cyc_cnt);
			$display("Something failed");
			$finish;
		end
	end

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		chk_cnt++;
		assert (got == exp) else begin
			err_cnt++;
			$display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	//////////////////////
	// Host port driver
	//////////////////////
	task automatic send_word(input logic [15:0] w);
		int n;
		i_io_din = w;
		tick();
		i_io_clk = 1'b1;
		n = 0;
		do begin
			tick();
			n++;
		end while (!o_io_ack);
		check_val("o_io_ack rise delay", n, 3);
		i_io_clk = 1'b0;
		n = 0;
		do begin
			tick();
			n++;
		end while (o_io_ack);
		check_val("o_io_ack fall delay", n, 3);
	endtask

	task automatic send_frame();
		i_io_uio = 1'b1;
		foreach (fr_q[i]) begin
			send_word(fr_q[i]);
		end
		i_io_uio = 1'b0;
		repeat (4) tick();
	endtask

	// Only data words after the command word touch a register
	task automatic model_frame();
		logic [7:0] code;
		code = fr_q[0][7:0];
		for (int i = 1; i < fr_q.size(); i++) begin
			case (code)
				`HPS_CMD_CFG: m_cfg = fr_q[i];
				`HPS_CMD_LED: {m_mask, m_state} = fr_q[i];
				`HPS_CMD_VOL: m_att = fr_q[i][4:0];
				default: ;
			endcase
		end
	endtask

	//////////////////////
	// Reference model
	//////////////////////
	function automatic logic [7:0] led_model(input logic pwr, input logic hdd);
		logic [7:0] dflt;
		dflt = {1'b0, i_pll_locked, 1'b0, pwr, 1'b0, hdd, 1'b0, i_led_user};
		return (m_mask & m_state) | (~m_mask & dflt);
	endfunction

	task automatic check_leds();
		logic pwr;
		logic hdd;
		pwr = i_led_power[1] & i_led_power[0];
		hdd = (i_led_disk[1] & i_led_disk[0]) | (~i_led_disk[1] & (i_led_disk[0] | i_hdd_act));
		check_val("o_led_power", o_led_power, pwr);
		check_val("o_led_hdd", o_led_hdd, hdd);
		check_val("o_led_user", o_led_user, i_led_user);
		check_val("o_led", o_led, led_model(pwr, hdd));
	endtask

	function automatic int chan_sum(input logic [15:0] core, input logic [15:0] lin);
		int c;
		c = i_audio_signed ? int'($signed(core)) : int'(core >> 1);
		return c + int'($signed(lin));
	endfunction

	function automatic int clamp16(input int v);
		if (v > 32767) return 32767;
		if (v < -32768) return -32768;
		return v;
	endfunction

	// Crossfeed in the 17-bit accumulator, which wraps
	function automatic int mix_model(input int own, input int other);
		int pre;
		int x;
		logic [16:0] acc;
		pre = other >>> 1;
		case (i_audio_mix)
			2'd0: x = own;
			2'd1: x = own - (own >>> 3) + (pre >>> 2);
			2'd2: x = own - (own >>> 2) + (pre >>> 1);
			default: x = (own >>> 1) + pre;
		endcase
		acc = x[16:0];
		x = int'($signed(acc));
		if (m_att[4]) x = 0;
		else x = x >>> m_att[3:0];
		return clamp16(x);
	endfunction

	// Near full scale on both inputs when saturating
	task automatic drive_audio(input logic sat);
		i_core_l = 16'($urandom());
		i_core_r = 16'($urandom());
		i_linux_l = 16'($urandom());
		i_linux_r = 16'($urandom());
		if (sat) begin
			i_core_l[15:12] = 4'h7;
			i_linux_l[15:12] = 4'h7;
			i_core_r[15:12] = 4'h8;
			i_linux_r[15:12] = 4'h8;
		end
	endtask

	initial begin
		seed_ret = $urandom(74);
		resetd = 1'b1;
		{i_io_clk, i_io_uio, i_io_din} = '0;
		{i_led_user, i_led_power, i_led_disk, i_hdd_act, i_pll_locked} = '0;
		{i_core_l, i_core_r, i_linux_l, i_linux_r} = '0;
		i_audio_signed = 1'b0;
		i_audio_mix = 2'd0;
		repeat (5) @(posedge clk_sys);
		#1;
		resetd = 1'b0;
		tick();
		check_val("o_io_ack", o_io_ack, 0);
		check_val("o_cfg", o_cfg, 0);
		check_val("o_led", o_led, 0);
		check_val("o_audio_l", o_audio_l, 0);
		check_val("o_audio_r", o_audio_r, 0);

		////////////////////
		// Config, bad and stray words
		////////////////////
		for (int f = 0; f < N_CFG + N_BAD; f++) begin
			fr_q.delete();
			if (f < N_CFG) begin
				fr_q.push_back({8'($urandom()), `HPS_CMD_CFG});
			end else begin
				fr_q.push_back({8'($urandom()), 8'h40 + 8'($urandom_range(63, 0))});
			end
			repeat ($urandom_range(3, 1)) fr_q.push_back(16'($urandom()));
			send_frame();
			model_frame();
			check_val("o_cfg", o_cfg, m_cfg);
			check_val("o_led", o_led, 0);
		end
		// A config command word outside a frame must not open one
		for (int w = 0; w < N_OUT; w++) begin
			if (w == 0) begin
				send_word({8'($urandom()), `HPS_CMD_CFG});
			end else begin
				send_word(16'($urandom()));
			end
		end
		check_val("o_cfg", o_cfg, m_cfg);

		////////////////////
		// LED override
		////////////////////
		for (int f = 0; f < N_LED; f++) begin
			fr_q.delete();
			fr_q.push_back({8'($urandom()), `HPS_CMD_LED});
			fr_q.push_back(16'($urandom()));
			send_frame();
			model_frame();
			for (int k = 0; k < N_LEDIN; k++) begin
				{i_led_user, i_led_power, i_led_disk, i_hdd_act, i_pll_locked} = 7'($urandom());
				tick();
				check_leds();
			end
		end

		////////////////////
		// Signed sums, no attenuation
		////////////////////
		i_audio_signed = 1'b1;
		i_audio_mix = 2'd0;
		for (int s = 0; s < N_SUM; s++) begin
			drive_audio(s[0]);
			repeat (HOLD) tick();
			check_val("o_audio_l", o_audio_l, clamp16(chan_sum(i_core_l, i_linux_l)));
			check_val("o_audio_r", o_audio_r, clamp16(chan_sum(i_core_r, i_linux_r)));
		end

		////////////////////
		// Crossfeed and volume
		////////////////////
		i_audio_signed = 1'b0;
		for (int s = 0; s < N_MIX; s++) begin
			drive_audio(1'b0);
			i_audio_mix = 2'($urandom());
			fr_q.delete();
			fr_q.push_back({8'($urandom()), `HPS_CMD_VOL});
			fr_q.push_back(16'($urandom_range(31, 0)));
			send_frame();
			model_frame();
			repeat (HOLD) tick();
			check_val("o_audio_l", o_audio_l, mix_model(chan_sum(i_core_l, i_linux_l),
				chan_sum(i_core_r, i_linux_r)));
			check_val("o_audio_r", o_audio_r, mix_model(chan_sum(i_core_r, i_linux_r),
				chan_sum(i_core_l, i_linux_l)));
		end

		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hps_sys.f ====
+incdir+hw
hw/hps_sys_pkg.sv
hw/hps_word_if.sv
hw/hps_io_link.sv
hw/hps_cmd_regs.sv
hw/status_leds.sv
hw/audio_mix_chan.sv
hw/hps_sys_top.sv
bench/hps_sys_asserts.sv
bench/tb_hps_sys.sv

// ==== Bender.yml ====
package:
  name: hps_sys

sources:
  - include_dirs:
      - hw
    files:
      - hw/hps_sys_pkg.sv
      - hw/hps_word_if.sv
      - hw/hps_io_link.sv
      - hw/hps_cmd_regs.sv
      - hw/status_leds.sv
      - hw/audio_mix_chan.sv
      - hw/hps_sys_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/hps_sys_asserts.sv
      - bench/tb_hps_sys.sv
